// ==== logic/scale_cfg_pkg.sv ====
package scale_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // array geometry
  ////////////////////////////////////////////////////////////

  // channels, one per systolic-array row
  localparam int sa_row_num     = 4;
  // output rows per array
  localparam int row_num_in_sa  = 16;
  localparam int scale_sets_num = sa_row_num * row_num_in_sa;
  localparam int set_addr_width = $clog2(scale_sets_num);
  // row index 0 means no valid sum, so 0..16
  localparam int row_idx_width  = 5;

  ////////////////////////////////////////////////////////////
  // scale storage
  ////////////////////////////////////////////////////////////

  localparam int scale_width      = 8;
  // parallel weight lanes per set
  localparam int lane_num         = 2;
  localparam int scale_set_width  = scale_width * lane_num;
  localparam int scale_word_width = 512;
  // 64 bytes or 32 sets per word
  localparam int scales_per_word  = scale_word_width / scale_width;
  localparam int sets_per_word    = scale_word_width / scale_set_width;
  localparam int set_idx_width    = $clog2(sets_per_word);
  // register range fields, start and size both 1..64
  localparam int range_width      = 7;

  ////////////////////////////////////////////////////////////
  // load sequencing
  ////////////////////////////////////////////////////////////

  localparam int desc_mode_width = 4;
  localparam int words_mode0     = 1;
  localparam int words_mode1     = 2;
  localparam int word_cnt_width  = 2;

  ////////////////////////////////////////////////////////////
  // requant arithmetic
  ////////////////////////////////////////////////////////////

  localparam int sum_width     = 24;
  localparam int out_width     = 8;
  // scale is a fraction in 1/256 steps
  localparam int requant_shift = 8;
  // signed sum times unsigned scale
  localparam int prod_width    = sum_width + scale_width;
  // half an lsb of the shifted result
  localparam int round_bias    = 1 << (requant_shift - 1);
  localparam int q_max         = (1 << (out_width - 1)) - 1;
  localparam int q_min         = -(1 << (out_width - 1));

endpackage

// ==== logic/scale_types_pkg.sv ====
package scale_types_pkg;

  import scale_cfg_pkg::*;

  ////////////////////////////////////////////////////////////
  // scale word, read two ways depending on the load mode
  ////////////////////////////////////////////////////////////

  // mode 0 sees 64 single scales, mode 1 sees 32 full sets
  typedef union packed {
    logic [scales_per_word-1:0][scale_width-1:0]   scale_bytes;
    logic [sets_per_word-1:0][scale_set_width-1:0] scale_sets;
  } scale_word_u;

  // tile descriptor, only modes 0 and 1 are legal
  typedef struct packed {
    logic [desc_mode_width-1:0] mode;
  } scale_desc_t;

  // one register-range write, loader to bank
  typedef struct packed {
    logic                   en;
    // 0 bytes, 1 sets
    logic                   mode;
    // first register, counted from 1
    logic [range_width-1:0] start;
    logic [range_width-1:0] size;
    scale_word_u            word;
  } scale_wr_t;

  ////////////////////////////////////////////////////////////
  // datapath beats
  ////////////////////////////////////////////////////////////

  // sums per channel and lane
  typedef struct packed {
    logic [row_idx_width-1:0]                                  row_idx;
    logic signed [sa_row_num-1:0][lane_num-1:0][sum_width-1:0] sums;
  } sum_beat_t;

  // int8 results, same layout as the sums
  typedef struct packed {
    logic [row_idx_width-1:0]                                  row_idx;
    logic signed [sa_row_num-1:0][lane_num-1:0][out_width-1:0] q;
  } result_beat_t;

  // one scale set per channel for the addressed row
  typedef logic [sa_row_num-1:0][scale_set_width-1:0] scale_row_t;

endpackage

// ==== logic/scale_tile_loader.sv ====
`timescale 1ns/1ps

module scale_tile_loader
  import scale_cfg_pkg::*;
  import scale_types_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  // descriptor channel
  input  logic        desc_valid,
  output logic        desc_ready,
  input  scale_desc_t desc,
  // scale word channel
  input  logic        word_valid,
  output logic        word_ready,
  input  scale_word_u word,
  // write port into the bank
  output scale_wr_t   wr,
  // unknown mode seen
  output logic        desc_error
);

  typedef enum logic {
    st_idle,
    st_busy
  } state_t;

  state_t                    state;
  // 0 bytes, 1 sets
  logic                      mode_q;
  logic [word_cnt_width-1:0] word_cnt;
  logic [word_cnt_width-1:0] last_cnt;
  logic                      desc_take;
  logic                      word_take;
  logic                      desc_bad;

  ////////////////////////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////////////////////////

  assign desc_ready = (state == st_idle);
  assign word_ready = (state == st_busy);
  assign desc_take  = desc_valid & desc_ready;
  assign word_take  = word_valid & word_ready;
  // anything past mode 1 is refused
  assign desc_bad   = (desc.mode > 1);

  // index of the final word in this tile
  assign last_cnt = mode_q ? word_cnt_width'(words_mode1 - 1)
                           : word_cnt_width'(words_mode0 - 1);

  ////////////////////////////////////////////////////////////
  // idle / busy sequencing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      mode_q     <= 1'b0;
      word_cnt   <= '0;
      desc_error <= 1'b0;
    end else begin
      // one-cycle pulse after a bad descriptor
      desc_error <= desc_take & desc_bad;
      case (state)
        st_idle: begin
          if (desc_take && !desc_bad) begin
            state    <= st_busy;
            mode_q   <= desc.mode[0];
            word_cnt <= '0;
          end
        end
        st_busy: begin
          if (word_take) begin
            if (word_cnt == last_cnt) begin
              state <= st_idle;
            end else begin
              word_cnt <= word_cnt + 1'b1;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // range write, lands on the same edge as the word
  ////////////////////////////////////////////////////////////

  always_comb begin
    wr.en   = word_take;
    wr.mode = mode_q;
    wr.word = word;
    if (mode_q) begin
      // word n covers registers 32n+1 .. 32n+32
      wr.start = range_width'(1 + int'(word_cnt) * sets_per_word);
      wr.size  = range_width'(sets_per_word);
    end else begin
      // single word fills the whole bank
      wr.start = range_width'(1);
      wr.size  = range_width'(scale_sets_num);
    end
  end

endmodule

// ==== logic/scale_regs.sv ====
`timescale 1ns/1ps

module scale_regs
  import scale_cfg_pkg::*;
  import scale_types_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  scale_wr_t                wr,
  // output row, 1..16, 0 for no sum
  input  logic [row_idx_width-1:0] row_idx,
  output scale_row_t               scale_row
);

  // register k holds set k+1 in 1-based numbering
  logic [scale_set_width-1:0]                      scale_tile [scale_sets_num];
  logic [scale_sets_num-1:0]                       wr_mask;
  logic [scale_sets_num-1:0][scale_set_width-1:0]  wr_sets;
  // last register of the range, one bit wider for the carry
  logic [range_width:0]                            range_end;

  ////////////////////////////////////////////////////////////
  // enable mask over start .. start+size-1
  ////////////////////////////////////////////////////////////

  assign range_end = {1'b0, wr.start} + {1'b0, wr.size} - 1'b1;

  always_comb begin
    for (int k = 0; k < scale_sets_num; k++) begin
      wr_mask[k] = wr.en &&
                   ((k + 1) >= int'(wr.start)) &&
                   ((k + 1) <= int'(range_end));
    end
  end

  ////////////////////////////////////////////////////////////
  // word decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic [range_width-1:0] offs;
    for (int k = 0; k < scale_sets_num; k++) begin
      // position of register k inside the written range
      offs = range_width'(k + 1) - wr.start;
      if (wr.mode) begin
        // full sets, both lanes from the word
        wr_sets[k] = wr.word.scale_sets[offs[set_idx_width-1:0]];
      end else begin
        // one byte per register, high lane cleared
        wr_sets[k] = {{(scale_set_width - scale_width){1'b0}},
                      wr.word.scale_bytes[k]};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // register bank
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < scale_sets_num; k++) begin
        scale_tile[k] <= '0;
      end
    end else begin
      for (int k = 0; k < scale_sets_num; k++) begin
        if (wr_mask[k]) begin
          scale_tile[k] <= wr_sets[k];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // combinational row read
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic [set_addr_width-1:0] addr;
    for (int c = 0; c < sa_row_num; c++) begin
      // channel c owns registers 16c .. 16c+15
      addr = set_addr_width'(c * row_num_in_sa + int'(row_idx) - 1);
      if (row_idx == '0) begin
        scale_row[c] = '0;
      end else begin
        scale_row[c] = scale_tile[addr];
      end
    end
  end

endmodule

// ==== logic/sum_requant.sv ====
`timescale 1ns/1ps

module sum_requant
  import scale_cfg_pkg::*;
  import scale_types_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  // accumulator sums in
  input  logic                     sum_valid,
  output logic                     sum_ready,
  input  sum_beat_t                sum,
  // scale lookup, answered in the same cycle
  output logic [row_idx_width-1:0] row_idx,
  input  scale_row_t               scale_row,
  // int8 results out
  output logic                     res_valid,
  input  logic                     res_ready,
  output result_beat_t             res
);

  // whole pipe moves when the output slot frees up
  logic advance;

  // stage 1 registers
  logic                                                s1_valid;
  logic [row_idx_width-1:0]                            s1_row;
  logic [sa_row_num-1:0][lane_num-1:0][prod_width-1:0] s1_prod;

  // combinational results of each stage
  logic [sa_row_num-1:0][lane_num-1:0][prod_width-1:0] prod;
  logic [sa_row_num-1:0][lane_num-1:0][out_width-1:0]  q_next;

  ////////////////////////////////////////////////////////////
  // ready chain
  ////////////////////////////////////////////////////////////

  // stage 2 empty or being drained
  assign advance   = ~res_valid | res_ready;
  assign sum_ready = advance;

  // scale lookup straight from the incoming beat
  assign row_idx = sum.row_idx;

  ////////////////////////////////////////////////////////////
  // stage 1, multiply
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic signed [sum_width-1:0]   s;
    logic signed [scale_width:0]   f;
    logic signed [prod_width:0]    p;
    for (int c = 0; c < sa_row_num; c++) begin
      for (int l = 0; l < lane_num; l++) begin
        s = $signed(sum.sums[c][l]);
        // lane 0 low byte, lane 1 high byte
        // zero-extended so the scale stays unsigned
        f = $signed({1'b0, scale_row[c][l*scale_width +: scale_width]});
        p = s * f;
        // 24 x 8 fits in 32 bits signed
        prod[c][l] = p[prod_width-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 2, round, shift and saturate
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic signed [prod_width:0] acc;
    for (int c = 0; c < sa_row_num; c++) begin
      for (int l = 0; l < lane_num; l++) begin
        acc = $signed(s1_prod[c][l]);
        // round half up before dropping the fraction
        acc = acc + round_bias;
        acc = acc >>> requant_shift;
        if (acc > q_max) begin
          q_next[c][l] = out_width'(q_max);
        end else if (acc < q_min) begin
          q_next[c][l] = out_width'(q_min);
        end else begin
          q_next[c][l] = acc[out_width-1:0];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // pipeline valids
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      res_valid <= 1'b0;
    end else if (advance) begin
      s1_valid  <= sum_valid;
      res_valid <= s1_valid;
    end
  end

  ////////////////////////////////////////////////////////////
  // pipeline payload
  ////////////////////////////////////////////////////////////

  // held while stalled, so res stays stable
  always_ff @(posedge clk) begin
    if (advance) begin
      s1_row      <= sum.row_idx;
      s1_prod     <= prod;
      // row index rides along with its data
      res.row_idx <= s1_row;
      res.q       <= q_next;
    end
  end

endmodule

// ==== logic/conv_scale_top.sv ====
`timescale 1ns/1ps

module conv_scale_top
  import scale_cfg_pkg::*;
  import scale_types_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  // tile descriptor
  input  logic         desc_valid,
  output logic         desc_ready,
  input  scale_desc_t  desc,
  // scale words
  input  logic         word_valid,
  output logic         word_ready,
  input  scale_word_u  word,
  // accumulator sums
  input  logic         sum_valid,
  output logic         sum_ready,
  input  sum_beat_t    sum,
  // requantized results
  output logic         res_valid,
  input  logic         res_ready,
  output result_beat_t res,
  // bad descriptor pulse
  output logic         desc_error
);

  ////////////////////////////////////////////////////////////
  // internal links
  ////////////////////////////////////////////////////////////

  // loader writes into the bank
  scale_wr_t                wr;
  // requantizer looks up one row at a time
  logic [row_idx_width-1:0] row_idx;
  scale_row_t               scale_row;

  // descriptor and words in, range writes out
  scale_tile_loader u_loader (
    .clk        (clk),
    .reset      (reset),
    .desc_valid (desc_valid),
    .desc_ready (desc_ready),
    .desc       (desc),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .word       (word),
    .wr         (wr),
    .desc_error (desc_error)
  );

  // 64 scale sets, written by range, read per row
  scale_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .wr        (wr),
    .row_idx   (row_idx),
    .scale_row (scale_row)
  );

  // two-stage scale, round and saturate
  sum_requant u_requant (
    .clk       (clk),
    .reset     (reset),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready),
    .sum       (sum),
    .row_idx   (row_idx),
    .scale_row (scale_row),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res)
  );

endmodule

// ==== test/tb_conv_scale.sv ====
`timescale 1ns/1ps

module tb_conv_scale
  import scale_cfg_pkg::*;
  import scale_types_pkg::*;
();

  // ~330 beats plus loads, gaps and stalls stay well under 1500 cycles
  localparam int          max_cycles = 4000;
  localparam logic [31:0] seed       = 32'hcbe379f0;

  logic         clk;
  logic         reset;
  logic         desc_valid;
  logic         desc_ready;
  scale_desc_t  desc;
  logic         word_valid;
  logic         word_ready;
  scale_word_u  word;
  logic         sum_valid;
  logic         sum_ready;
  sum_beat_t    sum;
  logic         res_valid;
  logic         res_ready;
  result_beat_t res;
  logic         desc_error;

  // reference copy of the 64 scale sets
  logic [scale_set_width-1:0] model_regs [scale_sets_num];
  // expected results, pushed at sum accept, popped at result accept
  result_beat_t               exp_q [$];
  logic [31:0]                rng_state;
  // separate stream for res_ready stalls
  logic [31:0]                stall_state;
  logic                       stall_en;
  logic                       held_valid;
  result_beat_t               held_res;
  int                         cycle_cnt = 0;
  int                         error_cnt = 0;

  conv_scale_top u_conv_scale_top (
    .clk        (clk),
    .reset      (reset),
    .desc_valid (desc_valid),
    .desc_ready (desc_ready),
    .desc       (desc),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .word       (word),
    .sum_valid  (sum_valid),
    .sum_ready  (sum_ready),
    .sum        (sum),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res        (res),
    .desc_error (desc_error)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // random numbers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // sum times scale/256, rounded half up, clipped to int8
  function automatic logic [out_width-1:0] requant(input logic [sum_width-1:0] s,
                                                   input logic [scale_width-1:0] f);
    longint p;
    p = longint'($signed(s)) * longint'(f);
    p = (p + 128) >>> 8;
    if (p > 127) begin
      p = 127;
    end else if (p < -128) begin
      p = -128;
    end
    return p[7:0];
  endfunction

  function automatic result_beat_t expect_beat(input sum_beat_t b);
    result_beat_t               e;
    logic [scale_set_width-1:0] set;
    e.row_idx = b.row_idx;
    for (int c = 0; c < sa_row_num; c++) begin
      // row 0 carries no sum, so no scale either
      if (b.row_idx == 0) begin
        set = '0;
      end else begin
        set = model_regs[c * row_num_in_sa + int'(b.row_idx) - 1];
      end
      for (int l = 0; l < lane_num; l++) begin
        e.q[c][l] = requant(b.sums[c][l], set[l*scale_width +: scale_width]);
      end
    end
    return e;
  endfunction

  function automatic sum_beat_t rand_beat(input logic [row_idx_width-1:0] row);
    sum_beat_t b;
    b.row_idx = row;
    for (int c = 0; c < sa_row_num; c++) begin
      for (int l = 0; l < lane_num; l++) begin
        b.sums[c][l] = sum_width'(next_rand());
      end
    end
    return b;
  endfunction

  function automatic scale_word_u rand_word();
    logic [scale_word_width-1:0] bits;
    bits = '0;
    for (int i = 0; i < scale_word_width / 32; i++) begin
      bits = {bits[scale_word_width-33:0], next_rand()};
    end
    return bits;
  endfunction

  // mode 0 byte k to register k low lane, mode 1 word n sets to 32n..32n+31
  task automatic update_model(input logic mode, input int idx, input scale_word_u w);
    if (mode) begin
      for (int j = 0; j < 32; j++) begin
        model_regs[32 * idx + j] = w.scale_sets[j];
      end
    end else begin
      for (int k = 0; k < 64; k++) begin
        model_regs[k] = {8'h00, w.scale_bytes[k]};
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checking and failure
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    error_cnt++;
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > max_cycles) begin
      fail_run($sformatf("timeout, tests did not finish within %0d cycles", max_cycles));
    end
  end

  // outputs are stable at the falling edge, sample handshakes there
  always @(negedge clk) begin
    result_beat_t e;
    if (!reset) begin
      // sums are taken whenever the output slot is free or draining
      check("sum_ready", sum_ready, !res_valid || res_ready);
      // stalled result must not move
      if (held_valid) begin
        check("res_valid", res_valid, 1'b1);
        check("res.row_idx", res.row_idx, held_res.row_idx);
        check("res.q", res.q, held_res.q);
      end
      held_valid = res_valid && !res_ready;
      held_res   = res;
      // pop before push so a spurious result cannot match a new beat
      if (res_valid && res_ready) begin
        if (exp_q.size() == 0) begin
          fail_run("a result came out with no sum beat waiting for it");
        end
        e = exp_q.pop_front();
        check("res.row_idx", res.row_idx, e.row_idx);
        check("res.q", res.q, e.q);
      end
      if (sum_valid && sum_ready) begin
        exp_q.push_back(expect_beat(sum));
      end
    end
  end

  // random res_ready stalls when enabled
  always @(posedge clk) begin
    #2;
    if (stall_en) begin
      stall_state = xorshift(stall_state);
      res_ready   = (stall_state[1:0] != 2'b00);
    end else begin
      res_ready = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic load_tile(input logic [desc_mode_width-1:0] mode);
    scale_word_u w;
    int          n;
    desc_valid = 1'b1;
    desc.mode  = mode;
    @(negedge clk);
    while (!desc_ready) @(negedge clk);
    step();
    desc_valid = 1'b0;
    n = (mode == 1) ? words_mode1 : words_mode0;
    for (int i = 0; i < n; i++) begin
      w          = rand_word();
      word_valid = 1'b1;
      word       = w;
      @(negedge clk);
      while (!word_ready) @(negedge clk);
      step();
      word_valid = 1'b0;
      update_model(mode[0], i, w);
    end
  endtask

  task automatic send_beat(input sum_beat_t b);
    sum_valid = 1'b1;
    sum       = b;
    @(negedge clk);
    while (!sum_ready) @(negedge clk);
    step();
    sum_valid = 1'b0;
  endtask

  task automatic send_all_rows();
    for (int r = 1; r <= row_num_in_sa; r++) begin
      send_beat(rand_beat(row_idx_width'(r)));
    end
  endtask

  // back on a drive slot once the last result has left
  task automatic wait_drain();
    @(negedge clk);
    while (exp_q.size() != 0) @(negedge clk);
    step();
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    sum_beat_t b;
    rng_state   = seed;
    stall_state = seed ^ 32'h9e3779b9;
    clk         = 1'b0;
    reset       = 1'b1;
    desc_valid  = 1'b0;
    desc        = '0;
    word_valid  = 1'b0;
    word        = '0;
    sum_valid   = 1'b0;
    sum         = '0;
    res_ready   = 1'b1;
    stall_en    = 1'b0;
    held_valid  = 1'b0;
    for (int k = 0; k < scale_sets_num; k++) begin
      model_regs[k] = '0;
    end
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;

    // reset state, bank reads all zero
    @(negedge clk);
    check("desc_ready", desc_ready, 1'b1);
    check("word_ready", word_ready, 1'b0);
    check("res_valid", res_valid, 1'b0);
    check("desc_error", desc_error, 1'b0);
    step();
    send_all_rows();
    wait_drain();

    // single-word load, high lanes stay zero
    load_tile(0);
    send_all_rows();
    wait_drain();

    // two-word load with saturation at both ends
    load_tile(1);
    send_all_rows();
    for (int r = 1; r <= row_num_in_sa; r++) begin
      for (int i = 0; i < 2; i++) begin
        b = rand_beat(row_idx_width'(r));
        for (int c = 0; c < sa_row_num; c++) begin
          for (int l = 0; l < lane_num; l++) begin
            b.sums[c][l] = (i == 0) ? 24'h7fffff : 24'h800000;
          end
        end
        send_beat(b);
      end
    end
    wait_drain();

    // row 0 beats, then a refused mode 5 descriptor
    repeat (4) send_beat(rand_beat('0));
    wait_drain();
    desc_valid = 1'b1;
    desc.mode  = 4'd5;
    @(negedge clk);
    while (!desc_ready) @(negedge clk);
    step();
    desc_valid = 1'b0;
    @(negedge clk);
    check("desc_error", desc_error, 1'b1);
    check("desc_ready", desc_ready, 1'b1);
    check("word_ready", word_ready, 1'b0);
    @(negedge clk);
    check("desc_error", desc_error, 1'b0);
    step();
    load_tile(1);
    send_all_rows();
    wait_drain();

    // back-pressure, random gaps and stalls
    stall_en = 1'b1;
    for (int i = 0; i < 200; i++) begin
      repeat (next_rand() % 3) step();
      send_beat(rand_beat(row_idx_width'(next_rand() % 17)));
    end
    wait_drain();
    stall_en = 1'b0;

    // mode 0 over mode 1 clears every high lane
    load_tile(0);
    send_all_rows();
    wait_drain();

    if (error_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
logic/scale_cfg_pkg.sv
logic/scale_types_pkg.sv
logic/scale_tile_loader.sv
logic/scale_regs.sv
logic/sum_requant.sv
logic/conv_scale_top.sv
test/tb_conv_scale.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the conv scale testbench with verilator
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module tb_conv_scale -f list.f \
  -o sim_conv_scale > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_conv_scale > sim.log 2>&1
grep -q "Simulation failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "no result in sim.log"; exit 1; }
echo "PASS"
